/* filelist.f */
+incdir+source
source/apb_bus_pkg.sv
source/apb_pkt_pkg.sv
source/gaxi_skid_buffer.sv
source/apb_slave_stub.sv
source/apb_reg_target.sv
source/apb_stub_top.sv
verification/apb_stub_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f filelist.f --top-module apb_stub_tb
	out=$$(./obj_dir/Vapb_stub_tb); echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

/* verification/apb_stub_input.txt */
// Columns in hex: pwrite paddr pwdata pstrb pprot expected_prdata expected_pslverr
// One APB access per line, replayed in order
0 000 00000000 0 1 a9b50001 0
0 004 00000000 0 1 00000000 0
0 008 00000000 0 1 00000000 0
0 00c 00000000 0 1 00000000 0
0 010 00000000 0 1 00000000 0
0 014 00000000 0 1 00000000 0
0 018 00000000 0 1 00000000 0
0 01c 00000000 0 1 00000000 0
0 020 00000000 0 1 00000000 0
0 024 00000000 0 1 00000000 0
0 028 00000000 0 1 00000000 0
0 02c 00000000 0 1 00000000 0
0 030 00000000 0 1 00000000 0
0 034 00000000 0 1 00000000 0
0 038 00000000 0 1 00000000 0
0 03c 00000000 0 1 00000000 0
1 008 12345678 f 0 00000000 0
0 008 00000000 0 0 12345678 0
1 008 aabbccdd 5 0 00000000 0
0 008 00000000 0 0 12bb56dd 0
1 040 deadbeef f 1 00000000 1
0 ffc 00000000 0 1 00000000 1
0 008 00000000 0 0 12bb56dd 0
1 000 ffffffff f 1 00000000 1
0 000 00000000 0 0 a9b50001 0
1 024 cafef00d f 0 00000000 1
0 024 00000000 0 1 00000000 0
1 024 cafef00d f 1 00000000 0
0 024 00000000 0 3 cafef00d 0
0 024 00000000 0 0 00000000 1

/* verification/apb_stub_tb.sv */
// Self-checking testbench for the APB completer stub
// Replays accesses from a data file and checks prdata and pslverr

`timescale 1ns/100ps
`default_nettype none

`include "apb_stub_cfg.svh"

module apb_stub_tb
    import apb_bus_pkg::*;
();

    localparam int PREADY_TIMEOUT = 50;

    logic     pclk;
    logic     rst_n;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;

    int       errors;
    int       checks;
    int       line_no;
    integer   fd;
    integer   code;
    integer   seed;
    integer   gap;
    string    line;

    // Fields of one line from the data file
    logic                       f_wr;
    logic [`APB_ADDR_WIDTH-1:0] f_addr;
    logic [`APB_DATA_WIDTH-1:0] f_wdata;
    logic [`APB_STRB_WIDTH-1:0] f_strb;
    logic [2:0]                 f_prot;
    logic [`APB_DATA_WIDTH-1:0] f_rdata;
    logic                       f_err;

    apb_stub_top dut (
        .pclk    (pclk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    always #50 pclk = ~pclk;

    // Bus idle for one cycle starting right after a rising edge
    task automatic idle_cycle();
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
        @(posedge pclk);
    endtask

    // Setup phase, then access phase held until pready
    // Returns right after the edge that completes the transfer
    task automatic run_access();
        int   waited;
        logic seen;
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= f_wr;
        apb_req.paddr   <= f_addr;
        apb_req.pwdata  <= f_wdata;
        apb_req.pstrb   <= f_strb;
        apb_req.pprot   <= f_prot;
        @(posedge pclk);
        apb_req.penable <= 1'b1;
        waited = 0;
        seen   = 1'b0;
        // Sample mid-cycle, away from the clock edge
        while (!seen && waited < PREADY_TIMEOUT) begin
            @(negedge pclk);
            if (apb_rsp.pready) begin
                seen = 1'b1;
            end else begin
                waited++;
            end
        end
        if (!seen) begin
            $display("Timeout: no pready after %0d cycles for the access on line %0d",
                     PREADY_TIMEOUT, line_no);
            errors++;
        end else begin
            checks++;
            assert (apb_rsp.prdata === f_rdata) else begin
                $display("ERR %0t apb_rsp.prdata expected %h actual %h (line %0d)",
                         $time, f_rdata, apb_rsp.prdata, line_no);
                errors++;
            end
            assert (apb_rsp.pslverr === f_err) else begin
                $display("ERR %0t apb_rsp.pslverr expected %b actual %b (line %0d)",
                         $time, f_err, apb_rsp.pslverr, line_no);
                errors++;
            end
        end
        @(posedge pclk);
    endtask

    initial begin
        pclk    = 1'b0;
        rst_n   = 1'b0;
        apb_req = '0;
        errors  = 0;
        checks  = 0;
        line_no = 0;
        seed    = 22935;
        repeat (2) @(posedge pclk);
        rst_n <= 1'b1;

        fd = $fopen("verification/apb_stub_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the input file verification/apb_stub_input.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                code = $fgets(line, fd);
                line_no++;
                if (code == 0 || line.len() < 2 || line.substr(0, 1) == "//") begin
                    continue;
                end
                code = $sscanf(line, "%h %h %h %h %h %h %h",
                               f_wr, f_addr, f_wdata, f_strb, f_prot, f_rdata, f_err);
                if (code != 7) begin
                    $display("Line %0d of the input file could not be parsed", line_no);
                    errors++;
                end else begin
                    // Zero to three idle cycles where zero gives back-to-back transfers
                    gap = $unsigned($random(seed)) % 4;
                    repeat (gap) idle_cycle();
                    run_access();
                end
            end
            $fclose(fd);
        end

        idle_cycle();
        if (checks == 0) begin
            $display("No access was checked, the input file held no usable lines");
            errors++;
        end
        $display("Accesses checked: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : apb_stub_tb

`default_nettype wire

/* source/apb_stub_top.sv */
// APB completer subsystem top
// Front end and register target joined by command and response channels

`timescale 1ns/100ps
`default_nettype none

module apb_stub_top
    import apb_bus_pkg::*, apb_pkt_pkg::*;
(
    input  logic     pclk,
    input  logic     rst_n,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

    logic     cmd_valid;
    logic     cmd_ready;
    cmd_pkt_t cmd;
    logic     rsp_valid;
    logic     rsp_ready;
    rsp_pkt_t rsp;

    apb_slave_stub u_front (
        .pclk      (pclk),
        .rst_n     (rst_n),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    apb_reg_target u_target (
        .pclk      (pclk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

endmodule : apb_stub_top

`default_nettype wire

/* source/apb_reg_target.sv */
// Register target with sixteen 32-bit registers behind a command/response channel
// Byte-strobed writes, read-only ID at register 0, privileged upper half

`timescale 1ns/100ps
`default_nettype none

`include "apb_stub_cfg.svh"

module apb_reg_target
    import apb_pkt_pkg::*;
(
    input  logic     pclk,
    input  logic     rst_n,
    input  logic     cmd_valid,
    output logic     cmd_ready,
    input  cmd_pkt_t cmd,
    output logic     rsp_valid,
    input  logic     rsp_ready,
    output rsp_pkt_t rsp
);

    localparam int IDX_W  = $clog2(`REG_COUNT);
    localparam int WORD_W = `APB_ADDR_WIDTH - 2;

    // Register 0 is a constant, so storage starts at 1
    logic [`APB_DATA_WIDTH-1:0] regs [1:`REG_COUNT-1];
    logic                       accept;
    logic [WORD_W-1:0]          word_idx;
    logic [IDX_W-1:0]           reg_idx;
    logic                       out_of_bank;
    logic                       ro_write;
    logic                       priv_fail;
    logic                       access_err;
    logic [`APB_DATA_WIDTH-1:0] read_word;

    assign cmd_ready = !rsp_valid || rsp_ready;
    assign accept    = cmd_valid && cmd_ready;

    // Low two address bits ignored
    assign word_idx    = cmd.paddr[`APB_ADDR_WIDTH-1:2];
    assign reg_idx     = word_idx[IDX_W-1:0];
    assign out_of_bank = (word_idx >= WORD_W'(`REG_COUNT));
    assign ro_write    = cmd.pwrite && (word_idx == '0);
    assign priv_fail   = !out_of_bank && (reg_idx >= IDX_W'(`REG_COUNT / 2)) && !cmd.pprot[0];
    assign access_err  = out_of_bank || ro_write || priv_fail;

    always_comb begin
        if (reg_idx == '0) begin
            read_word = `REG_ID_VALUE;
        end else begin
            read_word = regs[reg_idx];
        end
    end

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            for (int r = 1; r < `REG_COUNT; r++) begin
                regs[r] <= '0;
            end
        end else if (accept && cmd.pwrite && !access_err) begin
            for (int b = 0; b < `APB_STRB_WIDTH; b++) begin
                if (cmd.pstrb[b]) begin
                    regs[reg_idx][8*b +: 8] <= cmd.pwdata[8*b +: 8];
                end
            end
        end
    end

    // Single response slot that refills in the cycle it drains
    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else if (accept) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    always_ff @(posedge pclk) begin
        if (accept) begin
            rsp.pslverr <= access_err;
            rsp.prdata  <= (access_err || cmd.pwrite) ? '0 : read_word;
        end
    end

    a_rsp_held: assert property (@(posedge pclk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid);

endmodule : apb_reg_target

`default_nettype wire

/* source/apb_slave_stub.sv */
// APB front end of the completer stub
// Packs access phases into command packets and completes from response packets

`timescale 1ns/100ps
`default_nettype none

`include "apb_stub_cfg.svh"

module apb_slave_stub
    import apb_bus_pkg::*, apb_pkt_pkg::*;
(
    input  logic     pclk,
    input  logic     rst_n,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp,
    output logic     cmd_valid,
    input  logic     cmd_ready,
    output cmd_pkt_t cmd,
    input  logic     rsp_valid,
    output logic     rsp_ready,
    input  rsp_pkt_t rsp
);

    typedef enum logic [1:0] {
        st_idle = 2'b01,
        st_xfer = 2'b10
    } state_t;

    state_t   state;
    state_t   state_next;

    // Front end side of the command buffer
    logic     push_valid;
    logic     push_ready;
    cmd_pkt_t push_cmd;

    // Front end side of the response buffer
    logic     pop_valid;
    logic     pop_ready;
    rsp_pkt_t pop_rsp;

    gaxi_skid_buffer #(
        .payload_t (cmd_pkt_t),
        .DEPTH     (`SKID_DEPTH)
    ) u_cmd_buf (
        .pclk     (pclk),
        .rst_n    (rst_n),
        .wr_valid (push_valid),
        .wr_ready (push_ready),
        .wr_data  (push_cmd),
        .rd_valid (cmd_valid),
        .rd_ready (cmd_ready),
        .rd_data  (cmd)
    );

    gaxi_skid_buffer #(
        .payload_t (rsp_pkt_t),
        .DEPTH     (`SKID_DEPTH)
    ) u_rsp_buf (
        .pclk     (pclk),
        .rst_n    (rst_n),
        .wr_valid (rsp_valid),
        .wr_ready (rsp_ready),
        .wr_data  (rsp),
        .rd_valid (pop_valid),
        .rd_ready (pop_ready),
        .rd_data  (pop_rsp)
    );

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // Requester holds the access fields until pready
    assign push_cmd.pwrite = apb_req.pwrite;
    assign push_cmd.pprot  = apb_req.pprot;
    assign push_cmd.pstrb  = apb_req.pstrb;
    assign push_cmd.paddr  = apb_req.paddr;
    assign push_cmd.pwdata = apb_req.pwdata;

    always_comb begin
        state_next = state;
        push_valid = 1'b0;
        pop_ready  = 1'b0;
        apb_rsp    = '0;
        case (state)
            st_idle: begin
                // Valid stays up through the access phase until the buffer takes it
                if (apb_req.psel && apb_req.penable) begin
                    push_valid = 1'b1;
                    if (push_ready) begin
                        state_next = st_xfer;
                    end
                end
            end
            st_xfer: begin
                if (pop_valid) begin
                    apb_rsp.pready  = 1'b1;
                    apb_rsp.prdata  = pop_rsp.prdata;
                    apb_rsp.pslverr = pop_rsp.pslverr;
                    pop_ready       = 1'b1;
                    state_next      = st_idle;
                end
            end
            default: state_next = st_idle;
        endcase
    end

    a_pready_in_access: assert property (@(posedge pclk) disable iff (!rst_n)
        apb_rsp.pready |-> apb_req.psel && apb_req.penable);

endmodule : apb_slave_stub

`default_nettype wire

/* source/gaxi_skid_buffer.sv */
// Valid/ready skid buffer built as a small circular FIFO with registered output
// Ready on each side comes from state only, never from the other side

`timescale 1ns/100ps
`default_nettype none

module gaxi_skid_buffer #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 2
) (
    input  logic     pclk,
    input  logic     rst_n,
    input  logic     wr_valid,
    output logic     wr_ready,
    input  payload_t wr_data,
    output logic     rd_valid,
    input  logic     rd_ready,
    output payload_t rd_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // Pointer wrap for depths that are not a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + PTR_W'(1);
    endfunction

    assign wr_ready = (count != CNT_W'(DEPTH));
    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];
    assign push     = wr_valid && wr_ready;
    assign pop      = rd_valid && rd_ready;

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    // Entry storage written on push
    always_ff @(posedge pclk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Head entry must not move while the consumer stalls
    a_rd_data_stable: assert property (@(posedge pclk) disable iff (!rst_n)
        rd_valid && !rd_ready |=> $stable(rd_data));

endmodule : gaxi_skid_buffer

`default_nettype wire

/* source/apb_pkt_pkg.sv */
// Internal packet types between the APB front end and the register target
// Command carries one access and response carries its read data and error

`default_nettype none

`include "apb_stub_cfg.svh"

package apb_pkt_pkg;

    // One access phase, captured as-is
    typedef struct packed {
        logic                       pwrite;
        logic [2:0]                 pprot;
        logic [`APB_STRB_WIDTH-1:0] pstrb;
        logic [`APB_ADDR_WIDTH-1:0] paddr;
        logic [`APB_DATA_WIDTH-1:0] pwdata;
    } cmd_pkt_t;

    // Completion of one command
    // prdata is zero for writes and for failed accesses
    typedef struct packed {
        logic                       pslverr;
        logic [`APB_DATA_WIDTH-1:0] prdata;
    } rsp_pkt_t;

endpackage : apb_pkt_pkg

`default_nettype wire

/* source/apb_bus_pkg.sv */
// APB bus-side signal groups
// Requester and completer structs for the completer port

`default_nettype none

`include "apb_stub_cfg.svh"

package apb_bus_pkg;

    // Requester to completer
    typedef struct packed {
        logic                       psel;
        logic                       penable;
        logic [`APB_ADDR_WIDTH-1:0] paddr;
        logic                       pwrite;
        logic [`APB_DATA_WIDTH-1:0] pwdata;
        logic [`APB_STRB_WIDTH-1:0] pstrb;
        logic [2:0]                 pprot;
    } apb_req_t;

    // Completer back to requester
    typedef struct packed {
        logic [`APB_DATA_WIDTH-1:0] prdata;
        logic                       pready;
        logic                       pslverr;
    } apb_rsp_t;

endpackage : apb_bus_pkg

`default_nettype wire

/* source/apb_stub_cfg.svh */
// APB completer stub configuration
// Bus widths, skid buffer depth and register bank constants

`ifndef APB_STUB_CFG_SVH
`define APB_STUB_CFG_SVH

// APB bus widths
`define APB_ADDR_WIDTH 12
`define APB_DATA_WIDTH 32
`define APB_STRB_WIDTH 4

// Entries per skid buffer
`define SKID_DEPTH 2

// Register bank size in 32-bit words
`define REG_COUNT 16

// Read-only identification word at register 0
`define REG_ID_VALUE 32'hA9B5_0001

`endif
